// ==== rtl/dispatch_pkg.sv ====
`default_nettype none

package dispatch_pkg;

    parameter int PREG_WIDTH = 8;  // Physical register tag width

    // funct7 that marks the RV32M group inside OP_REG
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef enum logic [6:0] {
        OP_NONE   = 7'b0000000,
        OP_REG    = 7'b0110011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        UNIT_NONE = 3'd0,
        UNIT_ADD  = 3'd1,  // ALU, load/store, immediate
        UNIT_MUL  = 3'd2,
        UNIT_DIV  = 3'd3,  // Divide and remainder
        UNIT_BR   = 3'd4
    } exec_unit_e;

    typedef struct packed {
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic [3:0] alu_op;
        logic       alu_src1;
        logic       alu_src2;
        logic       jump;
        logic       branch;
        logic       pred_taken;  // Predictor said taken
        logic       pred_hit;    // BTB hit at fetch
        logic       spare;
    } dispatch_ctrl_t;

    typedef struct packed {
        logic [6:0]            opcode;  // Raw bits that may lie outside opcode_e
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [31:0]           operand1;
        logic [31:0]           operand2;
        logic [31:0]           pc;
        logic [31:0]           immediate;
        logic [31:0]           inst_num;
        logic [PREG_WIDTH-1:0] rd_phy;
        logic [PREG_WIDTH-1:0] src1_phy;
        logic [PREG_WIDTH-1:0] src2_phy;
        logic [1:0]            src_ready;  // Operand 1 and 2 ready flags
        dispatch_ctrl_t        ctrl;
    } dispatch_op_t;

endpackage

`default_nettype wire

// ==== rtl/unit_classifier.sv ====
`default_nettype none

module unit_classifier (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        in_valid,
    input  dispatch_pkg::dispatch_op_t in_op,
    output logic                       cls_valid,
    output dispatch_pkg::exec_unit_e   cls_unit,
    output dispatch_pkg::dispatch_op_t cls_op
);

    import dispatch_pkg::*;

    opcode_e    op;
    exec_unit_e unit_d;

    assign op = opcode_e'(in_op.opcode);

    // Steering rule ignores in_valid
    always_comb begin
        unit_d = UNIT_ADD;  // Anything unnamed is ALU work
        case (op)
            OP_NONE: begin
                unit_d = UNIT_NONE;
            end
            OP_REG: begin
                if (in_op.funct7 == FUNCT7_MULDIV) begin
                    // funct3[2] splits MUL* from DIV*/REM*
                    if (in_op.funct3[2]) begin
                        unit_d = UNIT_DIV;
                    end else begin
                        unit_d = UNIT_MUL;
                    end
                end else begin
                    unit_d = UNIT_ADD;
                end
            end
            OP_JAL, OP_JALR, OP_BRANCH: begin
                unit_d = UNIT_BR;
            end
            default: begin
                unit_d = UNIT_ADD;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cls_valid <= 1'b0;
            cls_unit  <= UNIT_NONE;
        end else begin
            cls_valid <= in_valid && (unit_d != UNIT_NONE);
            if (in_valid) begin
                cls_unit <= unit_d;
            end else begin
                cls_unit <= UNIT_NONE;
            end
        end
    end

    // Payload only moves with a valid input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            cls_op <= in_op;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dispatch_router.sv ====
`default_nettype none

module dispatch_router (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        cls_valid,
    input  dispatch_pkg::exec_unit_e   cls_unit,
    input  dispatch_pkg::dispatch_op_t cls_op,
    output logic                       add_issue,
    output logic                       mul_issue,
    output logic                       div_issue,
    output logic                       br_issue,
    output dispatch_pkg::dispatch_op_t add_entry,
    output dispatch_pkg::dispatch_op_t mul_entry,
    output dispatch_pkg::dispatch_op_t div_entry,
    output dispatch_pkg::dispatch_op_t br_entry
);

    import dispatch_pkg::*;

    logic add_sel;
    logic mul_sel;
    logic div_sel;
    logic br_sel;

    // One-hot station select
    always_comb begin
        add_sel = 1'b0;
        mul_sel = 1'b0;
        div_sel = 1'b0;
        br_sel  = 1'b0;
        if (cls_valid) begin
            case (cls_unit)
                UNIT_ADD: add_sel = 1'b1;
                UNIT_MUL: mul_sel = 1'b1;
                UNIT_DIV: div_sel = 1'b1;
                UNIT_BR:  br_sel  = 1'b1;
                default:  ;  // UNIT_NONE never arrives with cls_valid
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            add_issue <= 1'b0;
            mul_issue <= 1'b0;
            div_issue <= 1'b0;
            br_issue  <= 1'b0;
        end else begin
            add_issue <= add_sel;  // Single-cycle strobes
            mul_issue <= mul_sel;
            div_issue <= div_sel;
            br_issue  <= br_sel;
        end
    end

    // Each entry holds until its own station is chosen again
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            add_entry <= '0;
            mul_entry <= '0;
            div_entry <= '0;
            br_entry  <= '0;
        end else begin
            if (add_sel) begin
                add_entry <= cls_op;
            end
            if (mul_sel) begin
                mul_entry <= cls_op;
            end
            if (div_sel) begin
                div_entry <= cls_op;
            end
            if (br_sel) begin
                br_entry <= cls_op;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dispatch_top.sv ====
`default_nettype none

module dispatch_top (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        in_valid,
    input  dispatch_pkg::dispatch_op_t in_op,
    output logic                       add_issue,
    output logic                       mul_issue,
    output logic                       div_issue,
    output logic                       br_issue,
    output dispatch_pkg::dispatch_op_t add_entry,
    output dispatch_pkg::dispatch_op_t mul_entry,
    output dispatch_pkg::dispatch_op_t div_entry,
    output dispatch_pkg::dispatch_op_t br_entry
);

    import dispatch_pkg::*;

    logic         cls_valid;
    exec_unit_e   cls_unit;
    dispatch_op_t cls_op;

    unit_classifier u_classifier (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .cls_valid (cls_valid),
        .cls_unit  (cls_unit),
        .cls_op    (cls_op)
    );

    dispatch_router u_router (
        .clk       (clk),
        .reset     (reset),
        .cls_valid (cls_valid),
        .cls_unit  (cls_unit),
        .cls_op    (cls_op),
        .add_issue (add_issue),
        .mul_issue (mul_issue),
        .div_issue (div_issue),
        .br_issue  (br_issue),
        .add_entry (add_entry),
        .mul_entry (mul_entry),
        .div_entry (div_entry),
        .br_entry  (br_entry)
    );

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
`default_nettype none

module clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;  // Period of 20

endmodule

`default_nettype wire

// ==== test/dispatch_asserts.sv ====
`default_nettype none

module dispatch_asserts (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        in_valid,
    input  dispatch_pkg::dispatch_op_t in_op,
    input  wire                        add_issue,
    input  wire                        mul_issue,
    input  wire                        div_issue,
    input  wire                        br_issue
);

    logic [3:0] strobes;
    logic       qualifying;

    assign strobes    = {add_issue, mul_issue, div_issue, br_issue};
    assign qualifying = in_valid && (in_op.opcode != 7'd0);

    strobe_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(strobes))
        else $error("more than one issue strobe high in one cycle");

    strobe_in_reset: assert property (@(posedge clk) reset |-> (strobes == 4'b0000))
        else $error("issue strobe high while reset is asserted");

    // Two cycle latency from input to station
    issue_latency: assert property (@(posedge clk) disable iff (reset)
        $past(qualifying, 2) |-> $onehot(strobes))
        else $error("qualifying input not followed by one strobe two cycles later");

    no_stray_issue: assert property (@(posedge clk) disable iff (reset)
        !$past(qualifying, 2) |-> (strobes == 4'b0000))
        else $error("issue strobe without a qualifying input two cycles earlier");

endmodule

bind dispatch_top dispatch_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .add_issue (add_issue),
    .mul_issue (mul_issue),
    .div_issue (div_issue),
    .br_issue  (br_issue)
);

`default_nettype wire

// ==== test/dispatch_tb.sv ====
`default_nettype none

module dispatch_tb;

    import dispatch_pkg::*;

    localparam logic [6:0] OPC_NONE   = 7'b0000000;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    localparam int KIND_ANY    = 0;
    localparam int KIND_ADD    = 1;
    localparam int KIND_MULDIV = 2;
    localparam int KIND_BRANCH = 3;
    localparam int KIND_ZERO   = 4;
    localparam int DRAIN_LIMIT = 10;

    typedef struct packed {
        logic [31:0]  due;  // Cycle in which the strobe must show
        exec_unit_e   unit;
        dispatch_op_t op;
    } expect_t;

    logic         clk;
    logic         reset;
    logic         in_valid;
    dispatch_op_t in_op;
    logic         add_issue;
    logic         mul_issue;
    logic         div_issue;
    logic         br_issue;
    dispatch_op_t add_entry;
    dispatch_op_t mul_entry;
    dispatch_op_t div_entry;
    dispatch_op_t br_entry;

    logic [31:0]  lfsr = 32'hc7b72624;
    logic [31:0]  cyc = '0;
    logic [31:0]  inst_count = '0;
    expect_t      sb[$];
    dispatch_op_t model_add = '0;  // Last entry each station should hold
    dispatch_op_t model_mul = '0;
    dispatch_op_t model_div = '0;
    dispatch_op_t model_br = '0;
    int           checks = 0;
    int           errors = 0;
    int           test_checks = 0;
    int           test_errors = 0;
    int           tests_run = 0;
    int           tests_bad = 0;
    logic         aborted = 1'b0;

    clock_gen u_clock (
        .clk (clk)
    );

    dispatch_top dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .add_issue (add_issue),
        .mul_issue (mul_issue),
        .div_issue (div_issue),
        .br_issue  (br_issue),
        .add_entry (add_entry),
        .mul_entry (mul_entry),
        .div_entry (div_entry),
        .br_entry  (br_entry)
    );

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic dispatch_op_t random_payload();
        dispatch_op_t op;
        op.opcode    = 7'(take_bits(7));
        op.funct3    = 3'(take_bits(3));
        op.funct7    = 7'(take_bits(7));
        op.operand1  = take_bits(32);
        op.operand2  = take_bits(32);
        op.pc        = take_bits(32);
        op.immediate = take_bits(32);
        op.inst_num  = inst_count;
        inst_count   = inst_count + 32'd1;
        op.rd_phy    = PREG_WIDTH'(take_bits(PREG_WIDTH));
        op.src1_phy  = PREG_WIDTH'(take_bits(PREG_WIDTH));
        op.src2_phy  = PREG_WIDTH'(take_bits(PREG_WIDTH));
        op.src_ready = 2'(take_bits(2));
        op.ctrl      = 14'(take_bits(14));
        return op;
    endfunction

    function automatic dispatch_op_t make_op(input int kind);
        dispatch_op_t op;
        logic [31:0]  r;
        op = random_payload();
        case (kind)
            KIND_ADD: begin
                r = take_bits(1);
                if (r[0]) begin
                    op.opcode = OPC_REG;
                    if (op.funct7 == F7_MULDIV) op.funct7 = 7'b0100000;
                end else if (op.opcode inside {OPC_NONE, OPC_REG, OPC_JAL, OPC_JALR,
                                               OPC_BRANCH}) begin
                    op.opcode = OPC_IMM;
                end
            end
            KIND_MULDIV: begin
                op.opcode = OPC_REG;
                op.funct7 = F7_MULDIV;
            end
            KIND_BRANCH: begin
                r = take_bits(2);
                op.opcode = (r[1:0] == 2'd0) ? OPC_JAL : (r[1:0] == 2'd1) ? OPC_JALR : OPC_BRANCH;
            end
            KIND_ZERO: op.opcode = OPC_NONE;
            default: begin
                r = take_bits(3);  // Bias toward the named opcodes
                case (r[2:0])
                    3'd0: op.opcode = OPC_NONE;
                    3'd1: op.opcode = OPC_REG;
                    3'd2: op.opcode = OPC_JAL;
                    3'd3: op.opcode = OPC_JALR;
                    3'd4: op.opcode = OPC_BRANCH;
                    default: ;
                endcase
                r = take_bits(1);
                if (op.opcode == OPC_REG && r[0]) op.funct7 = F7_MULDIV;
            end
        endcase
        return op;
    endfunction

    // Reference steering decision
    function automatic exec_unit_e steer(input logic v, input dispatch_op_t op);
        if (!v || op.opcode == OPC_NONE) return UNIT_NONE;
        if (op.opcode == OPC_REG && op.funct7 == F7_MULDIV) begin
            if (op.funct3[2]) return UNIT_DIV;
            return UNIT_MUL;
        end
        if (op.opcode == OPC_JAL || op.opcode == OPC_JALR || op.opcode == OPC_BRANCH) begin
            return UNIT_BR;
        end
        return UNIT_ADD;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        test_checks++;
        assert (act === exp) else begin
            errors++;
            test_errors++;
            $display("ERR %s cycle %0d expected %h actual %h", name, cyc, exp, act);
        end
    endtask

    task automatic check_op(input string name, input dispatch_op_t exp, input dispatch_op_t act);
        checks++;
        test_checks++;
        assert (act === exp) else begin
            errors++;
            test_errors++;
            $display("ERR %s cycle %0d expected %h actual %h", name, cyc, exp, act);
        end
    endtask

    task automatic check_outputs();
        logic [3:0] exp_strobe;  // add mul div br
        expect_t    e;
        exp_strobe = 4'b0000;
        if (sb.size() != 0 && sb[0].due == cyc) begin
            e = sb.pop_front();
            case (e.unit)
                UNIT_ADD: begin
                    exp_strobe[3] = 1'b1;
                    model_add     = e.op;
                end
                UNIT_MUL: begin
                    exp_strobe[2] = 1'b1;
                    model_mul     = e.op;
                end
                UNIT_DIV: begin
                    exp_strobe[1] = 1'b1;
                    model_div     = e.op;
                end
                default: begin
                    exp_strobe[0] = 1'b1;
                    model_br      = e.op;
                end
            endcase
        end
        check_bit("add_issue", exp_strobe[3], add_issue);
        check_bit("mul_issue", exp_strobe[2], mul_issue);
        check_bit("div_issue", exp_strobe[1], div_issue);
        check_bit("br_issue", exp_strobe[0], br_issue);
        check_op("add_entry", model_add, add_entry);
        check_op("mul_entry", model_mul, mul_entry);
        check_op("div_entry", model_div, div_entry);
        check_op("br_entry", model_br, br_entry);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cyc = cyc + 32'd1;
        check_outputs();
    endtask

    task automatic send(input logic v, input dispatch_op_t op);
        expect_t e;
        next_cycle();
        in_valid = v;
        in_op    = op;
        e.unit   = steer(v, op);
        if (e.unit != UNIT_NONE) begin
            e.due = cyc + 32'd2;
            e.op  = op;
            sb.push_back(e);
        end
    endtask

    // Idle until every expected strobe has been seen
    task automatic drain(input string name);
        int n;
        n = 0;
        while (sb.size() != 0 && n < DRAIN_LIMIT) begin
            send(1'b0, random_payload());
            n++;
        end
        if (sb.size() != 0) begin
            aborted = 1'b1;
            errors++;
            test_errors++;
            $display("timeout in %s: %0d expected issues still pending after %0d cycles",
                     name, sb.size(), DRAIN_LIMIT);
        end else begin
            send(1'b0, random_payload());
            send(1'b0, random_payload());
        end
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-14s PASS  checks %0d", name, test_checks);
        end else begin
            tests_bad++;
            $display("test %-14s FAIL  errors %0d of %0d checks", name, test_errors, test_checks);
        end
    endtask

    task automatic run_kind(input string name, input int kind, input int count);
        start_test();
        for (int i = 0; i < count; i++) begin
            send(1'b1, make_op(kind));
        end
        drain(name);
        finish_test(name);
    endtask

    task automatic test_reset();
        start_test();
        for (int i = 0; i < 16; i++) begin
            next_cycle();
        end
        reset = 1'b0;
        for (int i = 0; i < 4; i++) begin
            send(1'b0, random_payload());
        end
        finish_test("reset");
    endtask

    task automatic test_idle();
        logic [31:0] r;
        start_test();
        for (int i = 0; i < 40; i++) begin
            r = take_bits(1);
            if (r[0]) begin
                send(1'b1, make_op(KIND_ZERO));
            end else begin
                send(1'b0, make_op(KIND_ANY));  // Valid low with any payload
            end
        end
        drain("idle_filter");
        finish_test("idle_filter");
    endtask

    task automatic test_stream();
        logic [31:0] r;
        int          sent;
        start_test();
        sent = 0;
        while (sent < 400) begin
            r = take_bits(2);
            if (r[1:0] == 2'd0) begin
                r = take_bits(2);
                for (int g = 0; g <= int'(r[1:0]); g++) begin
                    send(1'b0, make_op(KIND_ANY));
                end
            end
            send(1'b1, make_op(KIND_ANY));
            sent++;
        end
        drain("stream");
        finish_test("stream");
    endtask

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = '0;
        test_reset();
        if (!aborted) run_kind("add_steering", KIND_ADD, 60);
        if (!aborted) run_kind("muldiv_steering", KIND_MULDIV, 60);
        if (!aborted) run_kind("branch_steering", KIND_BRANCH, 60);
        if (!aborted) test_idle();
        if (!aborted) test_stream();
        $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dispatch_top.f ====
rtl/dispatch_pkg.sv
rtl/unit_classifier.sv
rtl/dispatch_router.sv
rtl/dispatch_top.sv
test/clock_gen.sv
test/dispatch_asserts.sv
test/dispatch_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module dispatch_tb -f dispatch_top.f \
		--Mdir obj_dir -o dispatch_sim
	./obj_dir/dispatch_sim | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
